// ==== Bender.yml ====
package:
  name: permu

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - permu_pkg.sv
      - permu_insn_queue.sv
      - permu_lane_shuffle.sv
      - permu_gather_unit.sv
      - permu_result_queue.sv
      - permu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_permu.sv

// ==== compile.f ====
+incdir+.
permu_pkg.sv
permu_insn_queue.sv
permu_lane_shuffle.sv
permu_gather_unit.sv
permu_result_queue.sv
permu_top.sv
tb_permu.sv

// ==== permu_consts.svh ====
// Sizing constants of the permutation unit, included by the package, the RTL and the testbench
`ifndef PERMU_CONSTS_SVH
`define PERMU_CONSTS_SVH

// Lane cluster geometry
`define PERMU_NUM_LANES 4
`define PERMU_NUM_BANKS 2
`define PERMU_ELEN 64

// Element layout of one operand beat
`define PERMU_EW 16
`define PERMU_ELEMS 32

// Index bits taken from each index element, so indices wrap modulo 32
`define PERMU_IDX_W 5

// Instruction queue and instruction ids
`define PERMU_INSN_DEPTH 4
`define PERMU_NR_VINSN 4

// Per-lane rows occupied by one vector register
`define PERMU_ROWS_PER_VREG 4

`endif

// ==== permu_gather_unit.sv ====
// Gather engine; takes an index beat and a data beat and holds the gathered vector
`timescale 1ns/1ps
`include "permu_consts.svh"

module permu_gather_unit import permu_pkg::*; (
   input  logic       clk_i,
   input  logic       rst_ni,
   // Issued instruction
   input  logic       issue_valid_i,
   input  pe_req_t    issue_req_i,
   // Operand beats in element order
   input  logic       operand_valid_i,
   output logic       operand_ready_o,
   input  elem_beat_t operand_i,
   // Gathered result
   output logic       result_valid_o,
   input  logic       result_ready_i,
   output elem_beat_t result_o,
   output vid_t       result_id_o,
   output logic [4:0] result_vd_o,
   output logic       issue_done_o
);

   gather_state_e state_d, state_q;
   elem_beat_t    idx_q;
   elem_beat_t    result_q;
   logic          take;

   assign operand_ready_o = issue_valid_i &&
                            ((state_q == GATHER_IDX) || (state_q == GATHER_DATA));
   assign take = operand_valid_i && operand_ready_o;

   assign result_valid_o = (state_q == GATHER_HOLD);
   assign issue_done_o   = result_valid_o && result_ready_i;
   assign result_o       = result_q;

   // The issue entry stays put until issue_done
   assign result_id_o = issue_req_i.id;
   assign result_vd_o = issue_req_i.vd;

   ////////////////////////////////////////////////////////////////////
   // FSM
   ////////////////////////////////////////////////////////////////////

   always_comb begin
      state_d = state_q;
      case (state_q)
         GATHER_IDX: begin
            if (take) begin
               state_d = GATHER_DATA;
            end
         end
         GATHER_DATA: begin
            if (take) begin
               state_d = GATHER_HOLD;
            end
         end
         GATHER_HOLD: begin
            if (result_ready_i) begin
               state_d = GATHER_IDX;
            end
         end
         default: state_d = GATHER_IDX;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         state_q <= GATHER_IDX;
      end else begin
         state_q <= state_d;
      end
   end

   // Output element e takes the data element selected by index e
   always_ff @(posedge clk_i) begin
      if (take && (state_q == GATHER_IDX)) begin
         idx_q <= operand_i;
      end
      if (take && (state_q == GATHER_DATA)) begin
         for (int e = 0; e < `PERMU_ELEMS; e++) begin
            result_q[e] <= operand_i[idx_q[e][`PERMU_IDX_W-1:0]];
         end
      end
   end

   // The issued instruction stays in place from its index beat until the hand-off
   a_issue_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (state_q != GATHER_IDX) |-> (issue_valid_i && $stable(issue_req_i)));

endmodule

// ==== permu_insn_queue.sv ====
// Instruction queue of the permutation unit; accepts sequencer requests, issues and commits them
`timescale 1ns/1ps
`include "permu_consts.svh"

module permu_insn_queue import permu_pkg::*; (
   input  logic                       clk_i,
   input  logic                       rst_ni,
   // Main sequencer
   input  pe_req_t                    pe_req_i,
   input  logic                       pe_req_valid_i,
   input  logic [`PERMU_NR_VINSN-1:0] pe_vinsn_running_i,
   output logic                       pe_req_ready_o,
   output pe_resp_t                   pe_resp_o,
   // Gather unit and result queue
   output logic                       issue_valid_o,
   output pe_req_t                    issue_req_o,
   input  logic                       issue_done_i,
   input  logic                       commit_i
);

   localparam int unsigned Depth = `PERMU_INSN_DEPTH;
   localparam int unsigned PtrW  = $clog2(Depth);
   localparam int unsigned CntW  = PtrW + 1;

   typedef logic [PtrW-1:0] pnt_t;
   typedef logic [CntW-1:0] cnt_t;

   function automatic pnt_t next_pnt(input pnt_t pnt);
      return (pnt == pnt_t'(Depth - 1)) ? '0 : pnt + 1'b1;
   endfunction

   pe_req_t queue_q [Depth];

   // Accept, issue and commit positions in the ring
   pnt_t accept_pnt_q, issue_pnt_q, commit_pnt_q;
   // Entries still to hand off, and entries still to commit
   cnt_t issue_cnt_q, commit_cnt_q;

   logic [`PERMU_NR_VINSN-1:0] running_d, running_q;
   pe_resp_t resp_d;
   pe_req_t  commit_req;
   logic     accept;

   assign pe_req_ready_o = (commit_cnt_q != cnt_t'(Depth));

   // Only new permutation requests are taken; the rest are dropped
   assign accept = pe_req_valid_i && pe_req_ready_o && (pe_req_i.vfu == VFU_PERM) &&
                   !running_q[pe_req_i.id];

   assign issue_valid_o = (issue_cnt_q != '0);
   assign issue_req_o   = queue_q[issue_pnt_q];
   assign commit_req    = queue_q[commit_pnt_q];

   always_comb begin
      running_d = running_q & pe_vinsn_running_i;
      if (accept) begin
         running_d[pe_req_i.id] = 1'b1;
      end
      resp_d = '0;
      if (commit_i) begin
         resp_d.vinsn_done[commit_req.id] = 1'b1;
      end
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         accept_pnt_q <= '0;
         issue_pnt_q  <= '0;
         commit_pnt_q <= '0;
         issue_cnt_q  <= '0;
         commit_cnt_q <= '0;
         running_q    <= '0;
         pe_resp_o    <= '0;
      end else begin
         if (accept) begin
            accept_pnt_q <= next_pnt(accept_pnt_q);
         end
         if (issue_done_i) begin
            issue_pnt_q <= next_pnt(issue_pnt_q);
         end
         if (commit_i) begin
            commit_pnt_q <= next_pnt(commit_pnt_q);
         end
         issue_cnt_q  <= issue_cnt_q + cnt_t'(accept) - cnt_t'(issue_done_i);
         commit_cnt_q <= commit_cnt_q + cnt_t'(accept) - cnt_t'(commit_i);
         running_q    <= running_d;
         pe_resp_o    <= resp_d;
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         queue_q[accept_pnt_q] <= pe_req_i;
      end
   end

   a_commit_cnt_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
      commit_cnt_q <= cnt_t'(Depth));

   // A commit can only come from an instruction already handed to the result queue
   a_commit_after_issue: assert property (@(posedge clk_i) disable iff (!rst_ni)
      commit_i |-> (commit_cnt_q > issue_cnt_q));

endmodule

// ==== permu_lane_shuffle.sv ====
// Element reordering between lane order and element order, one direction per instance
`timescale 1ns/1ps
`include "permu_consts.svh"

module permu_lane_shuffle import permu_pkg::*; #(
   // 0 turns lane order into element order, 1 the reverse
   parameter bit ToLanes = 1'b0
) (
   input  lane_beat_t lane_i,
   input  elem_beat_t elem_i,
   output lane_beat_t lane_o,
   output elem_beat_t elem_o
);

   localparam int unsigned NumLanes     = `PERMU_NUM_LANES;
   localparam int unsigned NumBanks     = `PERMU_NUM_BANKS;
   localparam int unsigned ElemsPerWord = `PERMU_ELEN / `PERMU_EW;

   // Element e sits in lane e mod 4 at slot e div 4
   // The slot picks the bank and the 16-bit position in the word
   if (ToLanes) begin : g_shuffle
      always_comb begin
         for (int l = 0; l < NumLanes; l++) begin
            for (int b = 0; b < NumBanks; b++) begin
               for (int p = 0; p < ElemsPerWord; p++) begin
                  lane_o[l][b][p*`PERMU_EW +: `PERMU_EW] =
                     elem_i[(b*ElemsPerWord + p)*NumLanes + l];
               end
            end
         end
      end
      assign elem_o = '0;
   end else begin : g_deshuffle
      always_comb begin
         for (int l = 0; l < NumLanes; l++) begin
            for (int b = 0; b < NumBanks; b++) begin
               for (int p = 0; p < ElemsPerWord; p++) begin
                  elem_o[(b*ElemsPerWord + p)*NumLanes + l] =
                     lane_i[l][b][p*`PERMU_EW +: `PERMU_EW];
               end
            end
         end
      end
      assign lane_o = '0;
   end

endmodule

// ==== permu_pkg.sv ====
// Shared types of the permutation unit, imported by every RTL module and the testbench
`include "permu_consts.svh"

package permu_pkg;

   ////////////////////////////////////////////////////////////////////
   // Sequencer interface
   ////////////////////////////////////////////////////////////////////

   typedef logic [$clog2(`PERMU_NR_VINSN)-1:0] vid_t;

   typedef enum logic [1:0] {
      VFU_ALU,
      VFU_MUL,
      VFU_LOAD,
      VFU_PERM
   } vfu_e;

   typedef struct packed {
      vid_t       id;
      vfu_e       vfu;
      logic [4:0] vd;
   } pe_req_t;

   // One done bit per instruction id
   typedef struct packed {
      logic [`PERMU_NR_VINSN-1:0] vinsn_done;
   } pe_resp_t;

   ////////////////////////////////////////////////////////////////////
   // Operand and result data
   ////////////////////////////////////////////////////////////////////

   typedef logic [`PERMU_ELEN-1:0] elen_t;
   typedef logic [7:0] vaddr_t;

   // Lane order: lane, then bank
   typedef elen_t [`PERMU_NUM_LANES-1:0][`PERMU_NUM_BANKS-1:0] lane_beat_t;

   // Element order: element 0 is the lowest
   typedef logic [`PERMU_ELEMS-1:0][`PERMU_EW-1:0] elem_beat_t;

   typedef struct packed {
      vid_t       id;
      vaddr_t     addr;
      lane_beat_t wdata;
   } payload_t;

   // Gather engine phases
   typedef enum logic [1:0] {
      GATHER_IDX,
      GATHER_DATA,
      GATHER_HOLD
   } gather_state_e;

endpackage

// ==== permu_result_queue.sv ====
// Single-entry result buffer that writes all lanes at once and commits on a full grant
`timescale 1ns/1ps
`include "permu_consts.svh"

module permu_result_queue import permu_pkg::*; (
   input  logic                         clk_i,
   input  logic                         rst_ni,
   // From the gather unit
   input  logic                         push_i,
   input  payload_t                     payload_i,
   output logic                         ready_o,
   // Lane write ports
   output logic   [`PERMU_NUM_LANES-1:0] result_req_o,
   output vid_t   [`PERMU_NUM_LANES-1:0] result_id_o,
   output vaddr_t [`PERMU_NUM_LANES-1:0] result_addr_o,
   output lane_beat_t                   result_wdata_o,
   input  logic   [`PERMU_NUM_LANES-1:0] result_gnt_i,
   // To the instruction queue
   output logic                         commit_o
);

   payload_t payload_q;
   logic     valid_q;

   assign ready_o = !valid_q;

   always_comb begin
      for (int l = 0; l < `PERMU_NUM_LANES; l++) begin
         result_req_o[l]  = valid_q;
         result_id_o[l]   = payload_q.id;
         result_addr_o[l] = payload_q.addr;
      end
   end
   assign result_wdata_o = payload_q.wdata;

   // Released only when every lane grants in the same cycle
   assign commit_o = &(result_req_o & result_gnt_i);

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         valid_q <= 1'b0;
      end else if (push_i) begin
         valid_q <= 1'b1;
      end else if (commit_o) begin
         valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (push_i) begin
         payload_q <= payload_i;
      end
   end

   // Without a full grant the request and its payload hold
   a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (valid_q && !commit_o) |=> (valid_q && $stable(payload_q)));

   a_push_when_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
      push_i |-> ready_o);

endmodule

// ==== permu_top.sv ====
// Permutation unit top level; connects instruction queue, shuffles, gather unit and result queue
`timescale 1ns/1ps
`include "permu_consts.svh"

module permu_top import permu_pkg::*; (
   input  logic                         clk_i,
   input  logic                         rst_ni,
   // Main sequencer
   input  pe_req_t                      pe_req_i,
   input  logic                         pe_req_valid_i,
   input  logic   [`PERMU_NR_VINSN-1:0] pe_vinsn_running_i,
   output logic                         pe_req_ready_o,
   output pe_resp_t                     pe_resp_o,
   // Operands in lane order
   input  logic                         operand_valid_i,
   output logic                         operand_ready_o,
   input  lane_beat_t                   operand_i,
   // Results to the lanes
   output logic   [`PERMU_NUM_LANES-1:0] permu_result_req_o,
   output vid_t   [`PERMU_NUM_LANES-1:0] permu_result_id_o,
   output vaddr_t [`PERMU_NUM_LANES-1:0] permu_result_addr_o,
   output lane_beat_t                   permu_result_wdata_o,
   input  logic   [`PERMU_NUM_LANES-1:0] permu_result_gnt_i
);

   logic       issue_valid, issue_done, commit;
   pe_req_t    issue_req;
   elem_beat_t operand_elem, result_elem;
   lane_beat_t result_lane;
   logic       result_valid, res_ready;
   vid_t       result_id;
   logic [4:0] result_vd;
   payload_t   payload;

   permu_insn_queue i_insn_queue (
      .clk_i              (clk_i),
      .rst_ni             (rst_ni),
      .pe_req_i           (pe_req_i),
      .pe_req_valid_i     (pe_req_valid_i),
      .pe_vinsn_running_i (pe_vinsn_running_i),
      .pe_req_ready_o     (pe_req_ready_o),
      .pe_resp_o          (pe_resp_o),
      .issue_valid_o      (issue_valid),
      .issue_req_o        (issue_req),
      .issue_done_i       (issue_done),
      .commit_i           (commit)
   );

   permu_lane_shuffle #(.ToLanes(1'b0)) i_deshuffle (
      .lane_i (operand_i),
      .elem_i ('0),
      .lane_o (),
      .elem_o (operand_elem)
   );

   permu_gather_unit i_gather (
      .clk_i           (clk_i),
      .rst_ni          (rst_ni),
      .issue_valid_i   (issue_valid),
      .issue_req_i     (issue_req),
      .operand_valid_i (operand_valid_i),
      .operand_ready_o (operand_ready_o),
      .operand_i       (operand_elem),
      .result_valid_o  (result_valid),
      .result_ready_i  (res_ready),
      .result_o        (result_elem),
      .result_id_o     (result_id),
      .result_vd_o     (result_vd),
      .issue_done_o    (issue_done)
   );

   permu_lane_shuffle #(.ToLanes(1'b1)) i_shuffle (
      .lane_i ('0),
      .elem_i (result_elem),
      .lane_o (result_lane),
      .elem_o ()
   );

   // Fixed stride of one vector register per lane
   assign payload.id    = result_id;
   assign payload.addr  = vaddr_t'(result_vd * `PERMU_ROWS_PER_VREG);
   assign payload.wdata = result_lane;

   permu_result_queue i_result_queue (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .push_i         (result_valid && res_ready),
      .payload_i      (payload),
      .ready_o        (res_ready),
      .result_req_o   (permu_result_req_o),
      .result_id_o    (permu_result_id_o),
      .result_addr_o  (permu_result_addr_o),
      .result_wdata_o (permu_result_wdata_o),
      .result_gnt_i   (permu_result_gnt_i),
      .commit_o       (commit)
   );

endmodule

// ==== tb_permu.sv ====
// Self-checking testbench of the permutation unit; run it as the simulation top with compile.f
`timescale 1ns/1ps
`include "permu_consts.svh"

module tb_permu import permu_pkg::*; ();

   localparam int NumTests   = 5;
   localparam int GntNone    = 0;
   localparam int GntAll     = 1;
   localparam int GntRand    = 2;
   localparam int GntPartial = 3;

   logic                          clk_i, rst_ni;
   pe_req_t                       pe_req_i;
   logic                          pe_req_valid_i, pe_req_ready_o;
   logic [`PERMU_NR_VINSN-1:0]    pe_vinsn_running_i;
   pe_resp_t                      pe_resp_o;
   logic                          operand_valid_i, operand_ready_o;
   lane_beat_t                    operand_i;
   logic [`PERMU_NUM_LANES-1:0]   permu_result_req_o, permu_result_gnt_i;
   vid_t [`PERMU_NUM_LANES-1:0]   permu_result_id_o;
   vaddr_t [`PERMU_NUM_LANES-1:0] permu_result_addr_o;
   lane_beat_t                    permu_result_wdata_o;

   integer seed = 32'h2ac5;
   int     errors, checks, tests_done, test_start_errs, gnt_mode;

   // Sequencer model: ids in flight, ids safe to reuse, expected done bits
   logic [`PERMU_NR_VINSN-1:0]    busy, id_free, exp_done;
   logic [`PERMU_NUM_LANES-1:0]   gnt;
   pe_req_t                       pend_q[$];
   payload_t                      exp_q[$];
   // Snapshot of a request that was not fully granted
   logic                          held;
   vid_t [`PERMU_NUM_LANES-1:0]   held_id;
   vaddr_t [`PERMU_NUM_LANES-1:0] held_addr;
   lane_beat_t                    held_wdata;

   permu_top permu_top_i (.*);

   always #2 clk_i = ~clk_i;

   //////////////////////////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////////////////////////

   // Element e is in lane e mod 4, slot e div 4; slot gives bank and 16-bit position
   function automatic logic [15:0] get_elem(input lane_beat_t b, input int e);
      int slot;
      slot = e / `PERMU_NUM_LANES;
      return b[e % `PERMU_NUM_LANES][slot / 4][(slot % 4) * 16 +: 16];
   endfunction

   function automatic lane_beat_t put_elem(input lane_beat_t b, input int e,
                                           input logic [15:0] v);
      int slot;
      slot = e / `PERMU_NUM_LANES;
      b[e % `PERMU_NUM_LANES][slot / 4][(slot % 4) * 16 +: 16] = v;
      return b;
   endfunction

   function automatic lane_beat_t gather_ref(input lane_beat_t idx, input lane_beat_t data);
      lane_beat_t res;
      int         sel;
      res = '0;
      for (int e = 0; e < `PERMU_ELEMS; e++) begin
         sel = int'(get_elem(idx, e)) % `PERMU_ELEMS;
         res = put_elem(res, e, get_elem(data, sel));
      end
      return res;
   endfunction

   function automatic lane_beat_t rand_beat();
      lane_beat_t b;
      for (int l = 0; l < `PERMU_NUM_LANES; l++) begin
         for (int k = 0; k < `PERMU_NUM_BANKS; k++) begin
            b[l][k] = {$random(seed), $random(seed)};
         end
      end
      return b;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Stimulus tasks, all called on a falling edge
   //////////////////////////////////////////////////////////////////////

   task automatic send_req(input vid_t rid, input logic [4:0] rvd);
      while (!id_free[rid]) @(negedge clk_i);
      busy[rid]          = 1'b1;
      id_free[rid]       = 1'b0;
      pe_vinsn_running_i = busy;
      pe_req_i           = '{id: rid, vfu: VFU_PERM, vd: rvd};
      pe_req_valid_i     = 1'b1;
      while (!pe_req_ready_o) @(negedge clk_i);
      @(negedge clk_i);
      pe_req_valid_i = 1'b0;
      pend_q.push_back(pe_req_i);
   endtask

   // One cycle of a request that the unit must drop
   task automatic drive_ignored(input vid_t rid, input vfu_e rvfu, input logic [4:0] rvd);
      pe_req_i       = '{id: rid, vfu: rvfu, vd: rvd};
      pe_req_valid_i = 1'b1;
      @(negedge clk_i);
      pe_req_valid_i = 1'b0;
   endtask

   task automatic send_beat(input lane_beat_t beat);
      operand_valid_i = 1'b1;
      operand_i       = beat;
      while (!operand_ready_o) @(negedge clk_i);
      @(negedge clk_i);
      operand_valid_i = 1'b0;
   endtask

   task automatic send_operands(input lane_beat_t idx, input lane_beat_t data);
      pe_req_t  req;
      payload_t pl;
      req      = pend_q.pop_front();
      pl.id    = req.id;
      // Four rows per vector register
      pl.addr  = {1'b0, req.vd, 2'b00};
      pl.wdata = gather_ref(idx, data);
      exp_q.push_back(pl);
      send_beat(idx);
      send_beat(data);
   endtask

   task automatic wait_idle();
      while (exp_q.size() != 0 || pend_q.size() != 0 || busy != '0 || id_free != '1) begin
         @(negedge clk_i);
      end
   endtask

   task automatic finish_test(input string name);
      tests_done++;
      $display("[%0t] test %0d %s: %0d errors", $time, tests_done, name,
               errors - test_start_errs);
      test_start_errs = errors;
   endtask

   //////////////////////////////////////////////////////////////////////
   // Grants, done bits and result comparison
   //////////////////////////////////////////////////////////////////////

   task automatic compare_result();
      payload_t pl;
      checks++;
      assert (exp_q.size() != 0) else begin
         errors++;
         $display("[%0t] lanes were written while no instruction was outstanding", $time);
      end
      if (exp_q.size() != 0) begin
         pl = exp_q.pop_front();
         checks++;
         assert (permu_result_wdata_o == pl.wdata) else begin
            errors++;
            $display("CHECK FAILED at %0t: id %0d wdata %h, expected %h", $time, pl.id,
                     permu_result_wdata_o, pl.wdata);
         end
         for (int l = 0; l < `PERMU_NUM_LANES; l++) begin
            checks++;
            assert (permu_result_id_o[l] == pl.id && permu_result_addr_o[l] == pl.addr) else begin
               errors++;
               $display("CHECK FAILED at %0t: lane %0d id %0d addr %0d, expected %0d and %0d",
                        $time, l, permu_result_id_o[l], permu_result_addr_o[l], pl.id, pl.addr);
            end
         end
         exp_done[pl.id] = 1'b1;
      end
   endtask

   always @(negedge clk_i) begin
      if (rst_ni) begin
         checks++;
         assert (pe_resp_o.vinsn_done == exp_done) else begin
            errors++;
            $display("CHECK FAILED at %0t: done bits %b, expected %b", $time,
                     pe_resp_o.vinsn_done, exp_done);
         end
         // An id freed here is reused only after the DUT mask has dropped it
         id_free            = id_free | ~busy;
         busy               = busy & ~pe_resp_o.vinsn_done;
         pe_vinsn_running_i = busy;
         for (int l = 0; l < `PERMU_NUM_LANES; l++) begin
            case (gnt_mode)
               GntAll:     gnt[l] = 1'b1;
               GntRand:    gnt[l] = ($random(seed) & 3) != 0;
               GntPartial: gnt[l] = (l != 0) && (($random(seed) & 1) != 0);
               default:    gnt[l] = 1'b0;
            endcase
         end
         permu_result_gnt_i = gnt;
         if (held) begin
            checks++;
            assert (permu_result_req_o == '1 && permu_result_id_o == held_id &&
                    permu_result_addr_o == held_addr && permu_result_wdata_o == held_wdata)
            else begin
               errors++;
               $display("CHECK FAILED at %0t: result request changed before a full grant",
                        $time);
            end
         end
         exp_done = '0;
         if (&(permu_result_req_o & gnt)) begin
            held = 1'b0;
            compare_result();
         end else begin
            held       = |permu_result_req_o;
            held_id    = permu_result_id_o;
            held_addr  = permu_result_addr_o;
            held_wdata = permu_result_wdata_o;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      lane_beat_t idx;
      clk_i              = 1'b0;
      rst_ni             = 1'b0;
      pe_req_i           = '0;
      pe_req_valid_i     = 1'b0;
      pe_vinsn_running_i = '0;
      operand_valid_i    = 1'b0;
      operand_i          = '0;
      permu_result_gnt_i = '0;
      errors             = 0;
      checks             = 0;
      tests_done         = 0;
      test_start_errs    = 0;
      gnt_mode           = GntNone;
      busy               = '0;
      id_free            = '1;
      exp_done           = '0;
      held               = 1'b0;
      repeat (5) @(negedge clk_i);
      rst_ni = 1'b1;
      @(negedge clk_i);

      // Identity index returns the data beat itself
      gnt_mode = GntAll;
      idx      = '0;
      for (int e = 0; e < `PERMU_ELEMS; e++) begin
         idx = put_elem(idx, e, 16'(e));
      end
      send_req(0, 5'd7);
      send_operands(idx, rand_beat());
      wait_idle();
      finish_test("identity gather");

      // Full 16-bit random indices, so most wrap modulo 32
      gnt_mode = GntRand;
      for (int n = 0; n < 6; n++) begin
         send_req(vid_t'(n % 4), 5'(n * 5 + 1));
         send_operands(rand_beat(), rand_beat());
      end
      wait_idle();
      finish_test("random gather");

      // Foreign unit and duplicate id are dropped
      gnt_mode = GntAll;
      send_req(1, 5'd10);
      drive_ignored(1, VFU_PERM, 5'd11);
      drive_ignored(2, VFU_ALU, 5'd12);
      drive_ignored(3, VFU_LOAD, 5'd13);
      send_operands(rand_beat(), rand_beat());
      wait_idle();
      repeat (10) @(negedge clk_i);
      checks++;
      assert (!operand_ready_o && permu_result_req_o == '0) else begin
         errors++;
         $display("CHECK FAILED at %0t: a dropped request reached the gather unit", $time);
      end
      finish_test("dropped requests");

      // Back-pressure from missing or partial grants
      gnt_mode = GntNone;
      send_req(0, 5'd3);
      send_req(1, 5'd9);
      send_req(2, 5'd12);
      send_operands(rand_beat(), rand_beat());
      send_operands(rand_beat(), rand_beat());
      gnt_mode = GntPartial;
      repeat (12) begin
         checks++;
         assert (!operand_ready_o && permu_result_req_o == '1) else begin
            errors++;
            $display("CHECK FAILED at %0t: operand_ready_o %b req %b while a result waits",
                     $time, operand_ready_o, permu_result_req_o);
         end
         @(negedge clk_i);
      end
      gnt_mode = GntRand;
      send_operands(rand_beat(), rand_beat());
      wait_idle();
      finish_test("grant back-pressure");

      // Four requests in a row fill the instruction queue
      gnt_mode = GntAll;
      for (int n = 0; n < 4; n++) begin
         send_req(vid_t'(n), 5'(n + 20));
      end
      checks++;
      assert (!pe_req_ready_o) else begin
         errors++;
         $display("CHECK FAILED at %0t: pe_req_ready_o high with a full queue", $time);
      end
      for (int n = 0; n < 4; n++) begin
         send_operands(rand_beat(), rand_beat());
      end
      wait_idle();
      checks++;
      assert (pe_req_ready_o) else begin
         errors++;
         $display("CHECK FAILED at %0t: pe_req_ready_o low after all commits", $time);
      end
      finish_test("full queue and done bits");

      $display("Tests: %0d, checks: %0d, errors: %0d", tests_done, checks, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

   // About 200 cycles per test
   initial begin
      repeat (NumTests * 200) @(posedge clk_i);
      $display("Watchdog timeout: the tests did not finish within %0d cycles", NumTests * 200);
      $display("Result: FAILED");
      $finish;
   end

endmodule
